// File: common/accelPkg.sv
`default_nettype none

package accelPkg;

    // memory side of the accelerator, one beat per memory controller write
    localparam int beatWidth = 512;

    // one complex sample is {imag, real}, real part sits in the low half
    localparam int sampleWidth = 64;
    localparam int partWidth = 32;   // each part is signed Q16.16
    localparam int fracBits = 16;

    // a beat carries eight samples, lane m is bits 64m+63 down to 64m
    localparam int lanesPerBeat = beatWidth / sampleWidth;

    // frame geometry
    localparam int frameSamples = 1024;
    localparam int frameBeats = frameSamples / lanesPerBeat;   // 128 beats per frame

    // index widths for samples, beats and lanes
    localparam int sampleIdxWidth = $clog2(frameSamples);   // 10
    localparam int beatIdxWidth = $clog2(frameBeats);       // 7
    localparam int laneIdxWidth = $clog2(lanesPerBeat);     // 3

    // a full memory beat
    typedef logic [beatWidth-1:0] beatT;

    // one packed complex sample
    typedef logic [sampleWidth-1:0] sampleT;

    // one signed component of a sample or of the coefficient
    typedef logic signed [partWidth-1:0] partT;

endpackage

`default_nettype wire

// File: filelist.f
common/accelPkg.sv
inputBuffer/aBufIn.sv
verilog/complexScaler.sv
verilog/resultPacker.sv
verilog/accelFrontEnd.sv
verification/accelFrontEnd_asserts.sv
verification/tbAccelFrontEnd.sv

// File: inputBuffer/aBufIn.sv
`timescale 1ns/1ps
`default_nettype none

// frame buffer between the memory controller and the scaler
// the host fills it with 128 beats, then it streams 1024 samples back out
module aBufIn
    import accelPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic wrEn,          // host strobe, one beat written per high cycle
    input  wire beatT dataIn,        // eight samples, lane 0 in the low bits
    output logic      bufReady,      // high while the buffer accepts writes
    output sampleT    sampleOut,     // one sample per cycle while draining
    output logic      sampleValid    // qualifies sampleOut
);

    // one entry per beat, unpacking into samples happens on the read side
    beatT mem [0:frameBeats-1];

    logic [beatIdxWidth-1:0] wrIdx;     // next beat slot to fill
    logic [sampleIdxWidth-1:0] rdIdx;   // next sample to send out

    logic [beatIdxWidth-1:0] rdBeat;
    logic [laneIdxWidth-1:0] rdLane;
    beatT rdWord;                       // beat that holds the current sample
    sampleT rdSample;

    logic wrAccept;    // a write that the buffer actually takes
    logic startDrain;  // edge that writes the final beat of the frame
    logic draining;    // a sample is fetched on this edge

    assign wrAccept = wrEn && bufReady;   // writes while draining are dropped
    assign startDrain = wrAccept && (wrIdx == beatIdxWidth'(frameBeats - 1));
    assign draining = startDrain || !bufReady;

    // sample index splits into beat (upper bits) and lane (lower bits)
    assign rdBeat = rdIdx[sampleIdxWidth-1:laneIdxWidth];
    assign rdLane = rdIdx[laneIdxWidth-1:0];
    assign rdWord = mem[rdBeat];
    assign rdSample = rdWord[rdLane*sampleWidth +: sampleWidth];

    // beat storage indexed by the write beat index
    always_ff @(posedge clk) begin
        if (wrAccept) begin
            mem[wrIdx] <= dataIn;
        end
    end

    // write beat index wraps to zero after the last beat of a frame
    always_ff @(posedge clk) begin
        if (rst) begin
            wrIdx <= '0;
        end else if (wrAccept) begin
            wrIdx <= wrIdx + 1'b1;
        end
    end

    // bufReady doubles as the fill/drain state
    always_ff @(posedge clk) begin
        if (rst) begin
            bufReady <= 1'b1;
        end else if (startDrain) begin
            bufReady <= 1'b0;      // frame complete, stop taking writes
        end else if (!bufReady && rdIdx == sampleIdxWidth'(frameSamples - 1)) begin
            bufReady <= 1'b1;      // last sample is leaving, open for the next frame
        end
    end

    // read index walks 0..1023 and wraps back to zero for the next frame
    always_ff @(posedge clk) begin
        if (rst) begin
            rdIdx <= '0;
            sampleValid <= 1'b0;
        end else begin
            sampleValid <= draining;
            if (draining) begin
                rdIdx <= rdIdx + 1'b1;
            end
        end
    end

    // registered sample output
    // sample 0 already leaves on the edge that writes the last beat,
    // since beat 0 has been in memory for a long time by then
    always_ff @(posedge clk) begin
        if (draining) begin
            sampleOut <= rdSample;
        end
    end

endmodule

`default_nettype wire

// File: verification/accelFrontEnd_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the top-level ports of the accelerator front end
module accelFrontEndAsserts
    import accelPkg::*;
(
    input wire logic clk,
    input wire logic rst,
    input wire logic wrEn,
    input wire logic bufReady,
    input wire logic dataOutValid,
    input wire logic lastBeat
);

    int failCount = 0;   // number of failed assertions so far

    // the host must not start a write burst while the buffer drains
    wrOnlyWhenReady: assert property (@(posedge clk) disable iff (rst)
        $rose(wrEn) |-> bufReady)
        else begin
            failCount++;
            $error("wrEn rose while bufReady was low");
        end

    // each output beat is a single cycle pulse
    validIsPulse: assert property (@(posedge clk) disable iff (rst)
        dataOutValid |=> !dataOutValid)
        else begin
            failCount++;
            $error("dataOutValid stayed high for two cycles");
        end

    lastNeedsValid: assert property (@(posedge clk) disable iff (rst)
        lastBeat |-> dataOutValid)   // the frame marker rides on a real beat
        else begin
            failCount++;
            $error("lastBeat was high without dataOutValid");
        end

    // buffer opens for writes straight out of reset
    readyAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> bufReady)
        else begin
            failCount++;
            $error("bufReady was low on the first cycle after reset");
        end

endmodule

bind accelFrontEnd accelFrontEndAsserts uAsserts (
    .clk         (clk),
    .rst         (rst),
    .wrEn        (wrEn),
    .bufReady    (bufReady),
    .dataOutValid(dataOutValid),
    .lastBeat    (lastBeat)
);

`default_nettype wire

// File: verification/tbAccelFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module tbAccelFrontEnd
    import accelPkg::*;
();

    localparam int clkPeriod = 4;
    localparam int testFrames = 5;   // frames written over the whole run

    logic clk;
    logic rst;
    logic wrEn;
    beatT dataIn;
    sampleT coef;
    logic bufReady;
    beatT dataOut;
    logic dataOutValid;
    logic lastBeat;

    beatT frameBuf [frameBeats];   // frame that the next write burst sends
    beatT expBeats [$];            // expected output beats in order
    bit   expLast [$];
    int   expCycle [$];            // edge on which each beat should be seen
    int   cycle = 0;
    int   sentCount = 0;
    int   rcvCount = 0;
    int   lastCount = 0;

    accelFrontEnd DUT (
        .clk         (clk),
        .rst         (rst),
        .wrEn        (wrEn),
        .dataIn      (dataIn),
        .coef        (coef),
        .bufReady    (bufReady),
        .dataOut     (dataOut),
        .dataOutValid(dataOutValid),
        .lastBeat    (lastBeat)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;   // all readers see the count before this edge

    task automatic failNow(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkBeat(input string name, input beatT got, input beatT want);
        if (got !== want) begin
            failNow($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic want);
        if (got !== want) begin
            failNow($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    // (a+bi)(c+di) in Q16.16, each part floored by 16 bits and cut to 32 bits
    function automatic sampleT scaleRef(input sampleT s, input sampleT k);
        longint a, b, c, d, re, im;
        a = $signed(s[31:0]);
        b = $signed(s[63:32]);
        c = $signed(k[31:0]);
        d = $signed(k[63:32]);
        re = (a * c - b * d) >>> 16;   // longint is signed, so this shift keeps the sign
        im = (a * d + b * c) >>> 16;
        return {im[31:0], re[31:0]};
    endfunction

    function automatic beatT scaleBeat(input beatT x, input sampleT k);
        beatT y;
        for (int m = 0; m < 8; m++) begin
            y[m*64 +: 64] = scaleRef(x[m*64 +: 64], k);
        end
        return y;
    endfunction

    task automatic fillRandom();
        for (int i = 0; i < frameBeats; i++) begin
            for (int w = 0; w < 16; w++) begin
                frameBuf[i][w*32 +: 32] = $urandom();
            end
        end
    endtask

    // checks every output beat for data, frame marker and arrival edge
    always @(posedge clk) begin
        beatT want;
        if (!rst) begin
            if (lastBeat && !dataOutValid) failNow("lastBeat went high outside a beat");
            if (dataOutValid) begin
                if (expBeats.size() == 0) failNow("an output beat came when none was due");
                want = expBeats.pop_front();
                checkBeat("dataOut", dataOut, want);
                checkFlag("lastBeat", lastBeat, expLast.pop_front());
                if (cycle != expCycle[0]) begin
                    failNow($sformatf("output beat seen on edge %0d instead of edge %0d",
                                      cycle, expCycle[0]));
                end
                void'(expCycle.pop_front());
                rcvCount <= rcvCount + 1;
                if (lastBeat) lastCount <= lastCount + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (DUT.uAsserts.failCount != 0) begin
            failNow("a protocol assertion on the DUT ports failed");
        end
    end

    // writes frameBuf once the buffer is ready and queues the expected beats
    task automatic runFrame(input sampleT k, input bit scaled, input bit watchReady);
        int e0;
        @(posedge clk);
        while (!bufReady) @(posedge clk);
        coef <= k;   // the previous frame has left stage one of the scaler by now
        for (int i = 0; i < frameBeats; i++) begin
            wrEn <= 1'b1;
            dataIn <= frameBuf[i];
            @(posedge clk);
        end
        wrEn <= 1'b0;
        e0 = cycle;   // edge that wrote the 128th beat
        for (int i = 0; i < frameBeats; i++) begin
            expBeats.push_back(scaled ? scaleBeat(frameBuf[i], k) : frameBuf[i]);
            expLast.push_back(i == frameBeats - 1);
            // pulse set 10 edges after e0 and seen by the monitor one edge later
            expCycle.push_back(e0 + 11 + 8 * i);
        end
        sentCount += frameBeats;
        if (watchReady) begin
            repeat (frameSamples - 1) begin
                @(posedge clk);
                checkFlag("bufReady", bufReady, 1'b0);
            end
            @(posedge clk);
            checkFlag("bufReady", bufReady, 1'b1);   // drain finished, open again
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (rcvCount < sentCount) begin
            @(posedge clk);
            waited++;
            if (waited > 1300) failNow("output beats stopped before the frame was drained");
        end
        repeat (16) @(posedge clk);   // idle tail catches any stray beat
    endtask

    task automatic testReset();
        checkFlag("bufReady", bufReady, 1'b1);
        repeat (20) begin
            @(posedge clk);
            checkFlag("dataOutValid", dataOutValid, 1'b0);
            checkFlag("lastBeat", lastBeat, 1'b0);
        end
    endtask

    task automatic testIdentity();
        fillRandom();
        runFrame(64'h0000_0000_0001_0000, 1'b0, 1'b0);   // output must equal input
        waitDrain();
    endtask

    task automatic testScaling();
        fillRandom();
        frameBuf[0][63:0] = {32'hFFFE_8000, 32'hFFFF_C000};   // -1.5i and -0.25 in lane 0
        runFrame({$urandom(), $urandom()}, 1'b1, 1'b0);
        waitDrain();
    endtask

    task automatic testBoundaries();
        int lastBefore;
        lastBefore = lastCount;
        fillRandom();
        runFrame({$urandom(), $urandom()}, 1'b1, 1'b1);
        waitDrain();
        if (lastCount != lastBefore + 1) failNow("lastBeat did not come exactly once in the frame");
    endtask

    task automatic testBackToBack();
        fillRandom();
        runFrame({$urandom(), $urandom()}, 1'b1, 1'b0);
        fillRandom();   // new data and a new coefficient, written as soon as bufReady returns
        runFrame({$urandom(), $urandom()}, 1'b1, 1'b0);
        waitDrain();
    endtask

    initial begin
        #((testFrames * 1300 + 500) * clkPeriod);
        failNow("watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(87701));
        rst <= 1'b1;
        wrEn <= 1'b0;
        dataIn <= '0;
        coef <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        testReset();
        testIdentity();
        testScaling();
        testBoundaries();
        testBackToBack();
        if (DUT.uAsserts.failCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            failNow("a protocol assertion on the DUT ports failed");
        end
    end

endmodule

`default_nettype wire

// File: verilog/accelFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

// front end of the streaming accelerator
// buffer -> scaler -> packer, with no back-pressure anywhere
// first output beat comes 10 cycles after the final write of a frame
module accelFrontEnd
    import accelPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   wrEn,       // host write strobe, only while bufReady is high
    input  wire beatT   dataIn,
    input  wire sampleT coef,       // complex coefficient, real part low
    output logic        bufReady,
    output beatT        dataOut,
    output logic        dataOutValid,
    output logic        lastBeat
);

    sampleT bufSample;      // buffer to scaler
    logic   bufSampleValid;
    sampleT scaledSample;   // scaler to packer
    logic   scaledSampleValid;

    // frame store, streams one sample per cycle once full
    aBufIn uBufIn (
        .clk        (clk),
        .rst        (rst),
        .wrEn       (wrEn),
        .dataIn     (dataIn),
        .bufReady   (bufReady),
        .sampleOut  (bufSample),
        .sampleValid(bufSampleValid)
    );

    // two cycle complex multiply
    complexScaler uScaler (
        .clk          (clk),
        .rst          (rst),
        .sampleIn     (bufSample),
        .sampleInValid(bufSampleValid),
        .coef         (coef),
        .scaledOut    (scaledSample),
        .scaledValid  (scaledSampleValid)
    );

    // eight samples per outgoing beat
    resultPacker uPacker (
        .clk          (clk),
        .rst          (rst),
        .scaledIn     (scaledSample),
        .scaledInValid(scaledSampleValid),
        .dataOut      (dataOut),
        .dataOutValid (dataOutValid),
        .lastBeat     (lastBeat)
    );

endmodule

`default_nettype wire

// File: verilog/complexScaler.sv
`timescale 1ns/1ps
`default_nettype none

// multiplies each sample by the host coefficient, both in Q16.16
// (a+bi)(c+di) = (ac-bd) + (ad+bc)i, two register stages
module complexScaler
    import accelPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire sampleT sampleIn,       // {imag, real} from the buffer
    input  wire logic   sampleInValid,
    input  wire sampleT coef,           // held stable by the host for a whole frame
    output sampleT      scaledOut,
    output logic        scaledValid
);

    partT a, b, c, d;

    // full precision partial products, stage one
    logic signed [2*partWidth-1:0] ac, bd, ad, bc;
    logic prodValid;

    // product sums before the fixed point shift
    logic signed [2*partWidth-1:0] reSum, imSum;
    logic signed [2*partWidth-1:0] reShift, imShift;

    assign a = partT'(sampleIn[partWidth-1:0]);          // sample real
    assign b = partT'(sampleIn[sampleWidth-1:partWidth]); // sample imag
    assign c = partT'(coef[partWidth-1:0]);              // coef real
    assign d = partT'(coef[sampleWidth-1:partWidth]);    // coef imag

    // stage one, the four multiplies
    always_ff @(posedge clk) begin
        if (sampleInValid) begin
            ac <= a * c;
            bd <= b * d;
            ad <= a * d;
            bc <= b * c;
        end
    end

    // sums only need bits 47:16 to be right, so 64 bit wrap is harmless
    assign reSum = ac - bd;
    assign imSum = ad + bc;
    assign reShift = reSum >>> fracBits;   // rounds toward minus infinity
    assign imShift = imSum >>> fracBits;

    // stage two, keep the low 32 bits of each shifted part
    always_ff @(posedge clk) begin
        if (prodValid) begin
            scaledOut <= {imShift[partWidth-1:0], reShift[partWidth-1:0]};
        end
    end

    // valid follows the data through both stages
    always_ff @(posedge clk) begin
        if (rst) begin
            prodValid <= 1'b0;
            scaledValid <= 1'b0;
        end else begin
            prodValid <= sampleInValid;
            scaledValid <= prodValid;
        end
    end

endmodule

`default_nettype wire

// File: verilog/resultPacker.sv
`timescale 1ns/1ps
`default_nettype none

// collects eight scaled samples into one beat for the return path
// lanes are filled in arrival order, lane 0 first
module resultPacker
    import accelPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire sampleT scaledIn,
    input  wire logic   scaledInValid,
    output beatT        dataOut,
    output logic        dataOutValid,   // one cycle pulse per full beat
    output logic        lastBeat        // marks beat 128 of the frame
);

    beatT packReg;                       // beat under construction
    logic [laneIdxWidth-1:0] laneCnt;    // lane the next sample lands in
    logic [beatIdxWidth-1:0] beatCnt;    // beats already sent in this frame

    logic laneFull;   // this sample completes the beat
    logic frameEnd;   // and that beat is the last of the frame

    assign laneFull = scaledInValid && (laneCnt == laneIdxWidth'(lanesPerBeat - 1));
    assign frameEnd = laneFull && (beatCnt == beatIdxWidth'(frameBeats - 1));

    // lane write, the eighth sample lands on the same edge as the valid pulse
    always_ff @(posedge clk) begin
        if (scaledInValid) begin
            packReg[laneCnt*sampleWidth +: sampleWidth] <= scaledIn;
        end
    end

    assign dataOut = packReg;   // only meaningful while dataOutValid is high

    // lane and beat counters both wrap on their own, which realigns each frame
    always_ff @(posedge clk) begin
        if (rst) begin
            laneCnt <= '0;
            beatCnt <= '0;
            dataOutValid <= 1'b0;
            lastBeat <= 1'b0;
        end else begin
            dataOutValid <= laneFull;
            lastBeat <= frameEnd;
            if (scaledInValid) begin
                laneCnt <= laneCnt + 1'b1;
            end
            if (laneFull) begin
                beatCnt <= beatCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
